// File: hw/csr_macros.svh
/*
 * Machine mode CSR addresses, field positions and interrupt codes for an RV32 hart.
 * Only machine mode exists, so supervisor and user addresses are not listed.
 */
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// ----------------------------------------------------------------------
// CSR addresses
// ----------------------------------------------------------------------
`define CSR_MSTATUS    12'h300   // Holds MIE and MPIE only
`define CSR_MIE        12'h304   // Interrupt enables
`define CSR_MTVEC      12'h305   // Trap vector base, direct mode
`define CSR_MSCRATCH   12'h340   // Scratch word for the trap handler
`define CSR_MEPC       12'h341   // Exception PC
`define CSR_MCAUSE     12'h342   // Trap cause
`define CSR_MIP        12'h344   // Pending lines, read only
`define CSR_MCYCLE     12'hB00   // Low half of the cycle counter
`define CSR_MINSTRET   12'hB02   // Low half of the retired counter
`define CSR_MCYCLEH    12'hB80   // High half of the cycle counter
`define CSR_MINSTRETH  12'hB82   // High half of the retired counter

// ----------------------------------------------------------------------
// Field bit positions
// ----------------------------------------------------------------------
`define MSTATUS_MIE    3         // Global machine interrupt enable
`define MSTATUS_MPIE   7         // Enable saved on trap entry
`define MIP_MSI        3         // Software line, same place in mie
`define MIP_MTI        7         // Timer line, same place in mie
`define MIP_MEI        11        // External line, same place in mie

// Interrupt codes that land in the low bits of mcause
`define IRQ_CODE_MSI   3
`define IRQ_CODE_MTI   7
`define IRQ_CODE_MEI   11

`endif

// File: hw/csr_pkg.sv
/*
 * Vector types shared by the CSR unit. Widths are fixed for RV32.
 * irq_vec_t packs the lines as {external, timer, software}.
 */
`default_nettype none

package csr_pkg;

   // One data word, the width of every CSR
   typedef logic [31:0] xlen_t;

   // CSR address as found in the instruction
   typedef logic [11:0] csr_addr_t;

   // Full width of mcycle and minstret
   typedef logic [63:0] cnt_t;

   // Bit 2 is external, bit 1 is timer, bit 0 is software
   typedef logic [2:0]  irq_vec_t;

endpackage

`default_nettype wire

// File: hw/csr_nxt_reg.sv
/*
 * Next state of every machine CSR. Purely combinational.
 * Trap entry and mret win over a software write in the same cycle.
 * The caller must never raise exc_flag and mret together.
 */
`default_nettype none

`include "csr_macros.svh"

module csr_nxt_reg
   import csr_pkg::*;
(
   input  logic      csr_wr,                  // Software write strobe
   input  csr_addr_t csr_addr,                // Address of the write
   input  xlen_t     csr_wr_data,             // Raw write data before masking

   input  logic      exc_flag,                // Retiring exception this cycle
   input  xlen_t     exc_cause,
   input  xlen_t     exc_pc,
   input  logic      mret,                    // Return from the trap handler
   input  logic      retire,                  // One instruction retires

   input  logic      cur_mie_bit,
   input  logic      cur_mpie_bit,
   input  xlen_t     cur_mie,
   input  xlen_t     cur_mtvec,
   input  xlen_t     cur_mepc,
   input  xlen_t     cur_mcause,
   input  xlen_t     cur_mscratch,
   input  cnt_t      cur_mcycle,
   input  cnt_t      cur_minstret,

   output logic      nxt_mie_bit,
   output logic      nxt_mpie_bit,
   output xlen_t     nxt_mie,
   output xlen_t     nxt_mtvec,
   output xlen_t     nxt_mepc,
   output xlen_t     nxt_mcause,
   output xlen_t     nxt_mscratch,
   output cnt_t      nxt_mcycle,
   output cnt_t      nxt_minstret
);

   always_comb begin
      // ----------------------------------------------------------------
      // Hold by default and let the counters advance
      // ----------------------------------------------------------------
      nxt_mie_bit  = cur_mie_bit;
      nxt_mpie_bit = cur_mpie_bit;
      nxt_mie      = cur_mie;
      nxt_mtvec    = cur_mtvec;
      nxt_mepc     = cur_mepc;
      nxt_mcause   = cur_mcause;
      nxt_mscratch = cur_mscratch;
      nxt_mcycle   = cur_mcycle + cnt_t'(1);              // Counts every cycle
      nxt_minstret = cur_minstret + cnt_t'(retire);       // Counts retired instructions

      // ----------------------------------------------------------------
      // Software writes with the field rules applied
      // ----------------------------------------------------------------
      if (csr_wr) begin
         case (csr_addr)
            `CSR_MSTATUS: begin
               nxt_mie_bit  = csr_wr_data[`MSTATUS_MIE];    // MPP is hardwired, so it is not stored
               nxt_mpie_bit = csr_wr_data[`MSTATUS_MPIE];
            end
            `CSR_MIE: begin
               nxt_mie           = '0;                        // Only the three machine enables exist
               nxt_mie[`MIP_MSI] = csr_wr_data[`MIP_MSI];
               nxt_mie[`MIP_MTI] = csr_wr_data[`MIP_MTI];
               nxt_mie[`MIP_MEI] = csr_wr_data[`MIP_MEI];
            end
            `CSR_MTVEC:     nxt_mtvec    = {csr_wr_data[31:2], 2'b00};   // Direct mode only
            `CSR_MEPC:      nxt_mepc     = {csr_wr_data[31:2], 2'b00};   // No compressed ISA
            `CSR_MCAUSE:    nxt_mcause   = csr_wr_data;
            `CSR_MSCRATCH:  nxt_mscratch = csr_wr_data;
            `CSR_MCYCLE:    nxt_mcycle   = {cur_mcycle[63:32], csr_wr_data};  // Increment skipped
            `CSR_MCYCLEH:   nxt_mcycle   = {csr_wr_data, cur_mcycle[31:0]};
            `CSR_MINSTRET:  nxt_minstret = {cur_minstret[63:32], csr_wr_data};
            `CSR_MINSTRETH: nxt_minstret = {csr_wr_data, cur_minstret[31:0]};
            default: ;                                     // mip and unknown addresses drop the write
         endcase
      end

      // ----------------------------------------------------------------
      // Trap entry and return override anything software wrote above
      // ----------------------------------------------------------------
      if (exc_flag) begin
         nxt_mepc     = {exc_pc[31:2], 2'b00};            // Word aligned return address
         nxt_mcause   = exc_cause;
         nxt_mpie_bit = cur_mie_bit;                       // Save the enable
         nxt_mie_bit  = 1'b0;                              // Handler starts with interrupts off
      end else if (mret) begin
         nxt_mie_bit  = cur_mpie_bit;                      // Restore the saved enable
         nxt_mpie_bit = 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: hw/csr_regs.sv
/*
 * State flip-flops of the machine CSRs. One cycle from nxt_* to cur_*.
 * Synchronous active low reset clears every register to zero.
 */
`default_nettype none

module csr_regs
   import csr_pkg::*;
(
   input  logic  clk_in,
   input  logic  rst_n,

   input  logic  nxt_mie_bit,
   input  logic  nxt_mpie_bit,
   input  xlen_t nxt_mie,
   input  xlen_t nxt_mtvec,
   input  xlen_t nxt_mepc,
   input  xlen_t nxt_mcause,
   input  xlen_t nxt_mscratch,
   input  cnt_t  nxt_mcycle,
   input  cnt_t  nxt_minstret,

   output logic  cur_mie_bit,
   output logic  cur_mpie_bit,
   output xlen_t cur_mie,
   output xlen_t cur_mtvec,
   output xlen_t cur_mepc,
   output xlen_t cur_mcause,
   output xlen_t cur_mscratch,
   output cnt_t  cur_mcycle,
   output cnt_t  cur_minstret
);

   always_ff @(posedge clk_in) begin
      if (!rst_n) begin
         cur_mie_bit  <= 1'b0;                 // Interrupts stay off until software enables them
         cur_mpie_bit <= 1'b0;
         cur_mie      <= '0;
         cur_mtvec    <= '0;
         cur_mepc     <= '0;
         cur_mcause   <= '0;
         cur_mscratch <= '0;
         cur_mcycle   <= '0;
         cur_minstret <= '0;
      end else begin
         cur_mie_bit  <= nxt_mie_bit;
         cur_mpie_bit <= nxt_mpie_bit;
         cur_mie      <= nxt_mie;
         cur_mtvec    <= nxt_mtvec;
         cur_mepc     <= nxt_mepc;
         cur_mcause   <= nxt_mcause;
         cur_mscratch <= nxt_mscratch;
         cur_mcycle   <= nxt_mcycle;
         cur_minstret <= nxt_minstret;
      end
   end

   // The next state logic must never store a misaligned vector or return address
   a_mtvec_aligned: assert property (@(posedge clk_in) disable iff (!rst_n)
      cur_mtvec[1:0] == 2'b00);
   a_mepc_aligned: assert property (@(posedge clk_in) disable iff (!rst_n)
      cur_mepc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: hw/csr_rd_mux.sv
/*
 * CSR read decode. Combinational, zero latency.
 * Unknown addresses return zero with rd_avail low.
 */
`default_nettype none

`include "csr_macros.svh"

module csr_rd_mux
   import csr_pkg::*;
(
   input  csr_addr_t rd_addr,
   input  irq_vec_t  irqs,                 // {external, timer, software}
   input  logic      mie_bit,
   input  logic      mpie_bit,
   input  xlen_t     mie,
   input  xlen_t     mtvec,
   input  xlen_t     mepc,
   input  xlen_t     mcause,
   input  xlen_t     mscratch,
   input  cnt_t      mcycle,
   input  cnt_t      minstret,

   output xlen_t     rd_data,
   output logic      rd_avail              // High when the address exists
);

   xlen_t mstatus_word;
   xlen_t mip_word;

   always_comb begin
      mstatus_word                = '0;
      mstatus_word[`MSTATUS_MIE]  = mie_bit;
      mstatus_word[`MSTATUS_MPIE] = mpie_bit;
      mstatus_word[12:11]         = 2'b11;       // MPP reads as machine mode
   end

   always_comb begin
      mip_word           = '0;
      mip_word[`MIP_MEI] = irqs[2];              // Lines are shown as they are, no latch
      mip_word[`MIP_MTI] = irqs[1];
      mip_word[`MIP_MSI] = irqs[0];
   end

   always_comb begin
      rd_data  = '0;
      rd_avail = 1'b1;
      case (rd_addr)
         `CSR_MSTATUS:   rd_data = mstatus_word;
         `CSR_MIE:       rd_data = mie;
         `CSR_MTVEC:     rd_data = mtvec;
         `CSR_MSCRATCH:  rd_data = mscratch;
         `CSR_MEPC:      rd_data = mepc;
         `CSR_MCAUSE:    rd_data = mcause;
         `CSR_MIP:       rd_data = mip_word;
         `CSR_MCYCLE:    rd_data = mcycle[31:0];
         `CSR_MCYCLEH:   rd_data = mcycle[63:32];
         `CSR_MINSTRET:  rd_data = minstret[31:0];
         `CSR_MINSTRETH: rd_data = minstret[63:32];
         default:        rd_avail = 1'b0;        // Data stays zero
      endcase
   end

endmodule

`default_nettype wire

// File: hw/csr_irq_ctrl.sv
/*
 * Machine interrupt detect with fixed priority MEI, MSI, MTI.
 * Combinational. irq_cause is zero whenever irq_flag is low.
 */
`default_nettype none

`include "csr_macros.svh"

module csr_irq_ctrl
   import csr_pkg::*;
(
   input  irq_vec_t irqs,                  // {external, timer, software}
   input  logic     mie_bit,               // mstatus.MIE
   input  xlen_t    mie,
   input  xlen_t    mtvec,

   output logic     irq_flag,              // Take an interrupt trap
   output xlen_t    irq_cause,             // Value for mcause
   output xlen_t    trap_pc                // Handler address
);

   irq_vec_t pending;

   // Only lines that are both raised and enabled can compete
   assign pending  = irqs & {mie[`MIP_MEI], mie[`MIP_MTI], mie[`MIP_MSI]};
   assign irq_flag = mie_bit & (|pending);
   assign trap_pc  = mtvec;                // Direct mode, so every trap goes to the base

   always_comb begin
      irq_cause = '0;
      if (irq_flag) begin
         if (pending[2])
            irq_cause = xlen_t'(`IRQ_CODE_MEI);     // External wins
         else if (pending[0])
            irq_cause = xlen_t'(`IRQ_CODE_MSI);     // Software beats timer
         else
            irq_cause = xlen_t'(`IRQ_CODE_MTI);
         irq_cause[31] = 1'b1;                       // Interrupt, not exception
      end
   end

endmodule

`default_nettype wire

// File: hw/csr_unit.sv
/*
 * Machine mode CSR unit for a single hart RV32 core, no S or U mode.
 * Reads are combinational. Writes, traps and counts land on the next rising edge.
 * The nxt_* port pair previews what a read returns after that edge.
 */
`default_nettype none

module csr_unit
   import csr_pkg::*;
(
   input  logic      clk_in,
   input  logic      rst_n,

   input  logic      ext_irq,              // Level lines
   input  logic      timer_irq,
   input  logic      sw_irq,

   input  logic      exc_flag,             // One cycle pulse from writeback
   input  xlen_t     exc_cause,
   input  xlen_t     exc_pc,
   input  logic      mret,
   input  logic      retire,

   input  logic      csr_wr,               // Committed write
   input  csr_addr_t csr_wr_addr,
   input  xlen_t     csr_wr_data,

   input  csr_addr_t csr_rd_addr,
   output xlen_t     csr_rd_data,
   output logic      csr_rd_avail,

   input  logic      nxt_csr_wr,           // Proposed write, never stored
   input  csr_addr_t nxt_csr_wr_addr,
   input  xlen_t     nxt_csr_wr_data,
   output xlen_t     nxt_csr_rd_data,

   output xlen_t     mepc,
   output xlen_t     trap_pc,
   output logic      irq_flag,
   output xlen_t     irq_cause
);

   irq_vec_t irqs;

   logic  cur_mie_bit, cur_mpie_bit;       // Current state
   xlen_t cur_mie, cur_mtvec, cur_mepc, cur_mcause, cur_mscratch;
   cnt_t  cur_mcycle, cur_minstret;

   logic  nxt_mie_bit, nxt_mpie_bit;       // Committed next state
   xlen_t nxt_mie, nxt_mtvec, nxt_mepc, nxt_mcause, nxt_mscratch;
   cnt_t  nxt_mcycle, nxt_minstret;

   logic  fwd_mie_bit, fwd_mpie_bit;       // Preview next state
   xlen_t fwd_mie, fwd_mtvec, fwd_mepc, fwd_mcause, fwd_mscratch;
   cnt_t  fwd_mcycle, fwd_minstret;

   assign irqs = {ext_irq, timer_irq, sw_irq};
   assign mepc = cur_mepc;

   // ----------------------------------------------------------------------
   // Committed path
   // ----------------------------------------------------------------------
   csr_nxt_reg u_nxt_commit (
      .csr_wr(csr_wr), .csr_addr(csr_wr_addr), .csr_wr_data(csr_wr_data),
      .exc_flag(exc_flag), .exc_cause(exc_cause), .exc_pc(exc_pc),
      .mret(mret), .retire(retire),
      .cur_mie_bit(cur_mie_bit), .cur_mpie_bit(cur_mpie_bit), .cur_mie(cur_mie),
      .cur_mtvec(cur_mtvec), .cur_mepc(cur_mepc), .cur_mcause(cur_mcause),
      .cur_mscratch(cur_mscratch), .cur_mcycle(cur_mcycle), .cur_minstret(cur_minstret),
      .nxt_mie_bit(nxt_mie_bit), .nxt_mpie_bit(nxt_mpie_bit), .nxt_mie(nxt_mie),
      .nxt_mtvec(nxt_mtvec), .nxt_mepc(nxt_mepc), .nxt_mcause(nxt_mcause),
      .nxt_mscratch(nxt_mscratch), .nxt_mcycle(nxt_mcycle), .nxt_minstret(nxt_minstret)
   );

   csr_regs u_regs (
      .clk_in(clk_in), .rst_n(rst_n),
      .nxt_mie_bit(nxt_mie_bit), .nxt_mpie_bit(nxt_mpie_bit), .nxt_mie(nxt_mie),
      .nxt_mtvec(nxt_mtvec), .nxt_mepc(nxt_mepc), .nxt_mcause(nxt_mcause),
      .nxt_mscratch(nxt_mscratch), .nxt_mcycle(nxt_mcycle), .nxt_minstret(nxt_minstret),
      .cur_mie_bit(cur_mie_bit), .cur_mpie_bit(cur_mpie_bit), .cur_mie(cur_mie),
      .cur_mtvec(cur_mtvec), .cur_mepc(cur_mepc), .cur_mcause(cur_mcause),
      .cur_mscratch(cur_mscratch), .cur_mcycle(cur_mcycle), .cur_minstret(cur_minstret)
   );

   csr_rd_mux u_rd_commit (
      .rd_addr(csr_rd_addr), .irqs(irqs),
      .mie_bit(cur_mie_bit), .mpie_bit(cur_mpie_bit), .mie(cur_mie),
      .mtvec(cur_mtvec), .mepc(cur_mepc), .mcause(cur_mcause), .mscratch(cur_mscratch),
      .mcycle(cur_mcycle), .minstret(cur_minstret),
      .rd_data(csr_rd_data), .rd_avail(csr_rd_avail)
   );

   csr_irq_ctrl u_irq (
      .irqs(irqs), .mie_bit(cur_mie_bit), .mie(cur_mie), .mtvec(cur_mtvec),
      .irq_flag(irq_flag), .irq_cause(irq_cause), .trap_pc(trap_pc)
   );

   // ----------------------------------------------------------------------
   // Preview path. Same next state logic fed by the proposed write
   // ----------------------------------------------------------------------
   csr_nxt_reg u_nxt_fwd (
      .csr_wr(nxt_csr_wr), .csr_addr(nxt_csr_wr_addr), .csr_wr_data(nxt_csr_wr_data),
      .exc_flag(exc_flag), .exc_cause(exc_cause), .exc_pc(exc_pc),
      .mret(mret), .retire(retire),
      .cur_mie_bit(cur_mie_bit), .cur_mpie_bit(cur_mpie_bit), .cur_mie(cur_mie),
      .cur_mtvec(cur_mtvec), .cur_mepc(cur_mepc), .cur_mcause(cur_mcause),
      .cur_mscratch(cur_mscratch), .cur_mcycle(cur_mcycle), .cur_minstret(cur_minstret),
      .nxt_mie_bit(fwd_mie_bit), .nxt_mpie_bit(fwd_mpie_bit), .nxt_mie(fwd_mie),
      .nxt_mtvec(fwd_mtvec), .nxt_mepc(fwd_mepc), .nxt_mcause(fwd_mcause),
      .nxt_mscratch(fwd_mscratch), .nxt_mcycle(fwd_mcycle), .nxt_minstret(fwd_minstret)
   );

   csr_rd_mux u_rd_fwd (
      .rd_addr(nxt_csr_wr_addr), .irqs(irqs),   // mip shows the lines as they are now
      .mie_bit(fwd_mie_bit), .mpie_bit(fwd_mpie_bit), .mie(fwd_mie),
      .mtvec(fwd_mtvec), .mepc(fwd_mepc), .mcause(fwd_mcause), .mscratch(fwd_mscratch),
      .mcycle(fwd_mcycle), .minstret(fwd_minstret),
      .rd_data(nxt_csr_rd_data), .rd_avail()     // The writer already knows the address exists
   );

   // Trap entry and return would fight over MIE and MPIE
   a_no_exc_with_mret: assert property (@(posedge clk_in) disable iff (!rst_n)
      !(exc_flag && mret));

endmodule

`default_nettype wire

// File: tb/tb_csr_unit.sv
/*
 * Random testbench for csr_unit with a reference model of every machine CSR.
 * Inputs change on the falling edge and outputs are checked 1 ns before the rising edge.
 * The irq lines are held for one cycle after a preview so that mip reads stay comparable.
 */
`default_nettype none

`include "csr_macros.svh"

module tb_csr_unit
   import csr_pkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int          CLK_PERIOD   = 10;
   localparam int          RESET_CYCLES = 8;
   localparam int          NUM_CYCLES   = 4000;
   localparam int          WATCHDOG_NS  = 2 * (NUM_CYCLES + RESET_CYCLES) * CLK_PERIOD;
   localparam logic [31:0] SEED         = 32'h2b932ac5;
   localparam xlen_t       MIE_MASK     = (32'd1 << `MIP_MEI) | (32'd1 << `MIP_MTI) |
                                          (32'd1 << `MIP_MSI);

   // Model copy of every stored CSR
   typedef struct packed {
      logic  mie_bit;
      logic  mpie_bit;
      xlen_t mie;
      xlen_t mtvec;
      xlen_t mepc;
      xlen_t mcause;
      xlen_t mscratch;
      cnt_t  mcycle;
      cnt_t  minstret;
   } csr_state_t;

   logic      clk_in = 1'b0;
   logic      rst_n;
   logic      ext_irq, timer_irq, sw_irq;
   logic      exc_flag, mret, retire;
   xlen_t     exc_cause, exc_pc;
   logic      csr_wr, nxt_csr_wr;
   csr_addr_t csr_wr_addr, csr_rd_addr, nxt_csr_wr_addr;
   xlen_t     csr_wr_data, nxt_csr_wr_data;
   xlen_t     csr_rd_data, nxt_csr_rd_data, mepc, trap_pc, irq_cause;
   logic      csr_rd_avail, irq_flag;

   csr_state_t model;
   int         errors;
   int         cyc;
   logic       preview_now;                 // This cycle drives nxt_* equal to the commit
   logic       fwd_pending;                 // Last cycle was a preview
   csr_addr_t  fwd_addr;
   xlen_t      fwd_val;

   csr_unit i_dut (
      .clk_in(clk_in), .rst_n(rst_n),
      .ext_irq(ext_irq), .timer_irq(timer_irq), .sw_irq(sw_irq),
      .exc_flag(exc_flag), .exc_cause(exc_cause), .exc_pc(exc_pc),
      .mret(mret), .retire(retire),
      .csr_wr(csr_wr), .csr_wr_addr(csr_wr_addr), .csr_wr_data(csr_wr_data),
      .csr_rd_addr(csr_rd_addr), .csr_rd_data(csr_rd_data), .csr_rd_avail(csr_rd_avail),
      .nxt_csr_wr(nxt_csr_wr), .nxt_csr_wr_addr(nxt_csr_wr_addr),
      .nxt_csr_wr_data(nxt_csr_wr_data), .nxt_csr_rd_data(nxt_csr_rd_data),
      .mepc(mepc), .trap_pc(trap_pc), .irq_flag(irq_flag), .irq_cause(irq_cause)
   );

   initial begin
      forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
   end

   // ----------------------------------------------------------------------
   // Reference model
   // ----------------------------------------------------------------------
   function automatic csr_state_t apply_rules(input csr_state_t s, input logic wr,
         input csr_addr_t a, input xlen_t d, input logic do_exc, input xlen_t cause,
         input xlen_t pc, input logic do_mret, input logic do_retire);
      csr_state_t n;
      n = s;
      n.mcycle = s.mcycle + 64'd1;                          // Free running
      if (do_retire)
         n.minstret = s.minstret + 64'd1;
      if (wr) begin
         case (a)
            `CSR_MSTATUS: begin
               n.mie_bit  = d[`MSTATUS_MIE];
               n.mpie_bit = d[`MSTATUS_MPIE];
            end
            `CSR_MIE:       n.mie      = d & MIE_MASK;
            `CSR_MTVEC:     n.mtvec    = d & ~32'h3;
            `CSR_MEPC:      n.mepc     = d & ~32'h3;
            `CSR_MCAUSE:    n.mcause   = d;
            `CSR_MSCRATCH:  n.mscratch = d;
            `CSR_MCYCLE:    n.mcycle   = {s.mcycle[63:32], d};   // Write replaces the count
            `CSR_MCYCLEH:   n.mcycle   = {d, s.mcycle[31:0]};
            `CSR_MINSTRET:  n.minstret = {s.minstret[63:32], d};
            `CSR_MINSTRETH: n.minstret = {d, s.minstret[31:0]};
            default: ;
         endcase
      end
      if (do_exc) begin                                     // Trap beats software
         n.mepc     = pc & ~32'h3;
         n.mcause   = cause;
         n.mpie_bit = s.mie_bit;
         n.mie_bit  = 1'b0;
      end else if (do_mret) begin
         n.mie_bit  = s.mpie_bit;
         n.mpie_bit = 1'b1;
      end
      return n;
   endfunction

   // Returns {avail, data}
   function automatic logic [32:0] read_csr(input csr_state_t s, input csr_addr_t a,
         input irq_vec_t lines);
      xlen_t w;
      case (a)
         `CSR_MSTATUS: begin
            w = 32'h0000_1800;                              // MPP fixed at machine mode
            w[`MSTATUS_MIE]  = s.mie_bit;
            w[`MSTATUS_MPIE] = s.mpie_bit;
            return {1'b1, w};
         end
         `CSR_MIP: begin
            w = '0;
            w[`MIP_MEI] = lines[2];
            w[`MIP_MTI] = lines[1];
            w[`MIP_MSI] = lines[0];
            return {1'b1, w};
         end
         `CSR_MIE:       return {1'b1, s.mie};
         `CSR_MTVEC:     return {1'b1, s.mtvec};
         `CSR_MEPC:      return {1'b1, s.mepc};
         `CSR_MCAUSE:    return {1'b1, s.mcause};
         `CSR_MSCRATCH:  return {1'b1, s.mscratch};
         `CSR_MCYCLE:    return {1'b1, s.mcycle[31:0]};
         `CSR_MCYCLEH:   return {1'b1, s.mcycle[63:32]};
         `CSR_MINSTRET:  return {1'b1, s.minstret[31:0]};
         `CSR_MINSTRETH: return {1'b1, s.minstret[63:32]};
         default:        return 33'd0;
      endcase
   endfunction

   // ----------------------------------------------------------------------
   // Stimulus
   // ----------------------------------------------------------------------
   function automatic csr_addr_t pick_addr();
      logic [3:0] k;
      k = 4'($urandom_range(0, 15));
      case (k)
         4'd0:    return `CSR_MSTATUS;
         4'd1:    return `CSR_MIE;
         4'd2:    return `CSR_MTVEC;
         4'd3:    return `CSR_MSCRATCH;
         4'd4:    return `CSR_MEPC;
         4'd5:    return `CSR_MCAUSE;
         4'd6:    return `CSR_MIP;
         4'd7:    return `CSR_MCYCLE;
         4'd8:    return `CSR_MCYCLEH;
         4'd9:    return `CSR_MINSTRET;
         4'd10:   return `CSR_MINSTRETH;
         4'd11:   return `CSR_MSTATUS;                      // Extra weight on the enable bits
         4'd12:   return `CSR_MIE;
         default: return csr_addr_t'($urandom);             // Almost always unknown
      endcase
   endfunction

   task automatic drive_reset_inputs();
      {ext_irq, timer_irq, sw_irq} = 3'b111;                 // Lines high while state is clear
      exc_flag    = 1'b0;
      mret        = 1'b0;
      retire      = ($urandom_range(0, 1) == 1);
      csr_wr      = ($urandom_range(0, 1) == 1);             // Reset must win over the write
      csr_wr_addr = pick_addr();
      csr_wr_data = $urandom;
      csr_rd_addr = pick_addr();
      nxt_csr_wr  = 1'b0;
      preview_now = 1'b0;
   endtask

   task automatic drive_random_inputs();
      exc_flag    = ($urandom_range(0, 15) == 0);
      mret        = !exc_flag && ($urandom_range(0, 15) == 0);
      exc_cause   = $urandom;
      exc_pc      = $urandom;
      retire      = ($urandom_range(0, 1) == 1);
      csr_wr      = ($urandom_range(0, 1) == 1);
      csr_wr_addr = pick_addr();
      csr_wr_data = $urandom;
      if ((exc_flag || mret) && $urandom_range(0, 1) == 1) begin
         csr_wr = 1'b1;                                     // Collide with the trap update
         case ($urandom_range(0, 2))
            0:       csr_wr_addr = `CSR_MSTATUS;
            1:       csr_wr_addr = `CSR_MEPC;
            default: csr_wr_addr = `CSR_MCAUSE;
         endcase
      end
      if (fwd_pending) begin
         csr_rd_addr = fwd_addr;                            // Read back the previewed CSR
      end else begin
         csr_rd_addr = pick_addr();
         {ext_irq, timer_irq, sw_irq} = 3'($urandom);
      end
      preview_now = ($urandom_range(0, 3) == 0);
      if (preview_now) begin
         nxt_csr_wr      = csr_wr;
         nxt_csr_wr_addr = csr_wr_addr;
         nxt_csr_wr_data = csr_wr_data;
      end else begin
         nxt_csr_wr      = ($urandom_range(0, 1) == 1);    // Unrelated proposal
         nxt_csr_wr_addr = pick_addr();
         nxt_csr_wr_data = $urandom;
      end
   endtask

   // ----------------------------------------------------------------------
   // Checks
   // ----------------------------------------------------------------------
   task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
      assert (got === exp) else begin
         errors++;
         $display("[FAIL] %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp) else begin
         errors++;
         $display("[FAIL] %0t ns: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_outputs(input logic in_reset);
      irq_vec_t    lines;
      irq_vec_t    pend;
      logic        flag_exp;
      xlen_t       cause_exp;
      logic [32:0] rd_exp;
      logic [32:0] fwd_exp;
      csr_state_t  nxt_model;
      lines = {ext_irq, timer_irq, sw_irq};
      rd_exp = read_csr(model, csr_rd_addr, lines);
      check_word("csr_rd_data", csr_rd_data, rd_exp[31:0]);
      check_bit("csr_rd_avail", csr_rd_avail, rd_exp[32]);
      check_word("mepc", mepc, model.mepc);
      check_word("trap_pc", trap_pc, model.mtvec);
      pend = lines & {model.mie[`MIP_MEI], model.mie[`MIP_MTI], model.mie[`MIP_MSI]};
      flag_exp = model.mie_bit && (pend != 3'b000);
      if (pend[2])
         cause_exp = 32'h8000_0000 | `IRQ_CODE_MEI;
      else if (pend[0])
         cause_exp = 32'h8000_0000 | `IRQ_CODE_MSI;
      else
         cause_exp = 32'h8000_0000 | `IRQ_CODE_MTI;
      check_bit("irq_flag", irq_flag, flag_exp);
      if (flag_exp)
         check_word("irq_cause", irq_cause, cause_exp);
      if (!in_reset) begin                                  // Preview ignores rst_n
         nxt_model = apply_rules(model, nxt_csr_wr, nxt_csr_wr_addr, nxt_csr_wr_data,
                                 exc_flag, exc_cause, exc_pc, mret, retire);
         fwd_exp = read_csr(nxt_model, nxt_csr_wr_addr, lines);
         check_word("nxt_csr_rd_data", nxt_csr_rd_data, fwd_exp[31:0]);
         if (fwd_pending)
            check_word("csr_rd_data after preview", csr_rd_data, fwd_val);
      end
   endtask

   task automatic step_model();
      if (!rst_n)
         model = '0;
      else
         model = apply_rules(model, csr_wr, csr_wr_addr, csr_wr_data,
                             exc_flag, exc_cause, exc_pc, mret, retire);
   endtask

   // ----------------------------------------------------------------------
   // Main sequence
   // ----------------------------------------------------------------------
   initial begin
      void'($urandom(SEED));
      rst_n           = 1'b0;
      {ext_irq, timer_irq, sw_irq} = 3'b000;
      exc_flag        = 1'b0;
      mret            = 1'b0;
      retire          = 1'b0;
      exc_cause       = '0;
      exc_pc          = '0;
      csr_wr          = 1'b0;
      csr_wr_addr     = '0;
      csr_wr_data     = '0;
      csr_rd_addr     = '0;
      nxt_csr_wr      = 1'b0;
      nxt_csr_wr_addr = '0;
      nxt_csr_wr_data = '0;
      model           = '0;
      errors          = 0;
      preview_now     = 1'b0;
      fwd_pending     = 1'b0;
      fwd_addr        = '0;
      fwd_val         = '0;
      for (cyc = 1; cyc < RESET_CYCLES; cyc++) begin   // First edge at 5 ns is also in reset
         @(negedge clk_in);
         drive_reset_inputs();
         #4;
         check_outputs(1'b1);
         @(posedge clk_in);
         step_model();
      end
      for (cyc = 0; cyc < NUM_CYCLES; cyc++) begin
         @(negedge clk_in);
         rst_n = 1'b1;
         drive_random_inputs();
         #4;
         check_outputs(1'b0);
         fwd_pending = preview_now;
         fwd_addr    = nxt_csr_wr_addr;
         fwd_val     = nxt_csr_rd_data;
         @(posedge clk_in);
         step_model();
      end
      $display("Run finished after %0d cycles with %0d errors", NUM_CYCLES, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired, the run took longer than its time limit");
      $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hw
hw/csr_pkg.sv
hw/csr_nxt_reg.sv
hw/csr_regs.sv
hw/csr_rd_mux.sv
hw/csr_irq_ctrl.sv
hw/csr_unit.sv
tb/tb_csr_unit.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_csr_unit
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# The pipe status is that of grep, so a missing pass line fails the target
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
